// File: ahbm_top.f
hw/ahbm_pkg.sv
hw/ahbm_word_buffer.sv
hw/ahbm_data_phase.sv
hw/ahbm_sequencer.sv
hw/ahbm_top.sv
bench/ahbm_slave_model.sv
bench/ahbm_tb.sv

// File: bench/ahbm_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

module ahbm_slave_model (
   input  wire                           hclk,
   input  wire                           hreset,
   input  wire                           hbusreq_i,
   output logic                          hgrant_o,
   input  wire ahbm_pkg::ahb_ctrl_t      ahb_ctrl_i,
   input  wire [ahbm_pkg::HDATA_W-1:0]   hwdata_i,
   output logic                          hready_o,
   output ahbm_pkg::hresp_t              hresp_o,
   output logic [ahbm_pkg::HDATA_W-1:0]  hrdata_o
);
   import ahbm_pkg::*;

   logic                 dp_valid;     // A beat is in its data phase
   logic                 dp_write;
   logic [7:0]           dp_widx;      // Word index in the 1 KB window
   logic [1:0]           wait_cnt;     // Wait states still to insert
   logic                 active;
   logic [HDATA_W-1:0]   mem [256];
   logic [255:0]         written;      // Words that hold write data

   assign active   = (ahb_ctrl_i.htrans == NONSEQ) || (ahb_ctrl_i.htrans == SEQ);
   assign hready_o = !dp_valid || (wait_cnt == 2'd0);
   assign hresp_o  = OKAY;

   always_ff @(posedge hclk) begin
      if (!hreset) begin
         hgrant_o <= 1'b0;
         dp_valid <= 1'b0;
         dp_write <= 1'b0;
         dp_widx  <= '0;
         wait_cnt <= 2'd0;
         hrdata_o <= '0;
         written  <= '0;
      end else begin
         // Grant on request and keep it until the address phases are over
         if (hbusreq_i) begin
            hgrant_o <= 1'b1;
         end else if ((ahb_ctrl_i.htrans == IDLE) && hready_o) begin
            hgrant_o <= 1'b0;
         end

         if (hready_o) begin
            if (dp_valid && dp_write) begin
               mem[dp_widx]     <= hwdata_i;    // Completed write beat
               written[dp_widx] <= 1'b1;
            end
            dp_valid <= active;
            dp_write <= ahb_ctrl_i.hwrite;
            dp_widx  <= ahb_ctrl_i.haddr[9:2];
            if (active) begin
               wait_cnt <= 2'($urandom_range(0, 3));
               // Written words read back and the rest are random
               if (written[ahb_ctrl_i.haddr[9:2]]) begin
                  hrdata_o <= mem[ahb_ctrl_i.haddr[9:2]];
               end else begin
                  hrdata_o <= $urandom;
               end
            end else begin
               wait_cnt <= 2'd0;
            end
         end else begin
            wait_cnt <= wait_cnt - 2'd1;
         end
      end
   end

endmodule

`default_nettype wire

// File: bench/ahbm_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ahbm_tb;
   import ahbm_pkg::*;

   localparam int          PERIOD   = 8;
   localparam int          NUM_CMDS = 40;
   localparam int          TIMEOUT  = 400;
   localparam logic [31:0] SEED     = 32'h0f5f06ed;
   localparam logic [31:0] BASE     = 32'h0000_2000;   // 1 KB window

   logic                 hclk = 1'b0;
   logic                 hreset;
   dma_cmd_t             cmd_i;
   logic                 cmd_valid_i;
   logic                 busy_o;
   logic                 hgrant;
   logic                 hbusreq;
   ahb_ctrl_t            ahb_ctrl;
   logic                 hready;
   hresp_t               hresp;
   logic [HDATA_W-1:0]   hwdata;
   logic [HDATA_W-1:0]   hrdata;

   // Expected-value model
   logic                 cmd_seen;
   dma_cmd_t             exp_cmd;
   logic [HADDR_W-1:0]   exp_addr;
   logic [4:0]           exp_left;     // Beats still due
   logic                 exp_first;
   logic                 tdp_valid;
   logic                 tdp_write;
   logic [5:0]           tdp_idx;
   logic [HDATA_W-1:0]   shadow [64];
   logic                 filled [64];
   logic                 beat_on_bus;

   always #(PERIOD / 2) hclk = !hclk;

   ahbm_top ahbm_top_inst (
      .hclk        (hclk),
      .hreset      (hreset),
      .cmd_i       (cmd_i),
      .cmd_valid_i (cmd_valid_i),
      .busy_o      (busy_o),
      .hgrant_i    (hgrant),
      .hbusreq_o   (hbusreq),
      .ahb_ctrl_o  (ahb_ctrl),
      .hready_i    (hready),
      .hresp_i     (hresp),
      .hwdata_o    (hwdata),
      .hrdata_i    (hrdata)
   );

   ahbm_slave_model slave_inst (
      .hclk       (hclk),
      .hreset     (hreset),
      .hbusreq_i  (hbusreq),
      .hgrant_o   (hgrant),
      .ahb_ctrl_i (ahb_ctrl),
      .hwdata_i   (hwdata),
      .hready_o   (hready),
      .hresp_o    (hresp),
      .hrdata_o   (hrdata)
   );

   function automatic logic [4:0] beats_of(input hburst_t burst);
      case (burst)
         INCR4:   beats_of = 5'd4;
         INCR8:   beats_of = 5'd8;
         INCR16:  beats_of = 5'd16;
         default: beats_of = 5'd1;
      endcase
   endfunction

   task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      $display("Error: time %0t, %s is %h, expected %h", $time, name, got, exp);
      $display("Test FAILED");
      $fatal(1, "value mismatch");
   endtask

   task automatic fail_msg(input string text);
      $display("At time %0t: %s", $time, text);
      $display("Test FAILED");
      $fatal(1, "check failed");
   endtask

   // ************************************************************************
   // Expected-value tracking
   // ************************************************************************
   assign beat_on_bus = (ahb_ctrl.htrans == NONSEQ) || (ahb_ctrl.htrans == SEQ);

   always_ff @(posedge hclk) begin
      if (!hreset) begin
         cmd_seen  <= 1'b0;
         exp_left  <= '0;
         exp_first <= 1'b0;
         tdp_valid <= 1'b0;
      end else begin
         if (cmd_valid_i) cmd_seen <= 1'b1;
         if (cmd_valid_i && !busy_o) begin
            exp_cmd   <= cmd_i;
            exp_addr  <= cmd_i.addr;
            exp_left  <= beats_of(cmd_i.burst);
            exp_first <= 1'b1;
         end
         if (hready) begin
            tdp_valid <= beat_on_bus;
            tdp_write <= ahb_ctrl.hwrite;
            tdp_idx   <= ahb_ctrl.haddr[7:2];
            if (tdp_valid && !tdp_write) shadow[tdp_idx] <= hrdata;
            if (beat_on_bus) begin
               exp_addr  <= exp_addr + 32'd4;
               exp_left  <= exp_left - 5'd1;
               exp_first <= 1'b0;
            end
         end
      end
   end

   // ************************************************************************
   // Checks
   // ************************************************************************
   a_idle_start: assert property (@(negedge hclk)
      !cmd_seen |-> (!hbusreq && ahb_ctrl.htrans == IDLE && !busy_o))
      else fail_msg("bus or busy active before the first command");

   a_beat_addr: assert property (@(posedge hclk) disable iff (!hreset)
      beat_on_bus |-> ahb_ctrl.haddr == exp_addr)
      else fail_value("haddr", $sampled(ahb_ctrl.haddr), $sampled(exp_addr));

   a_beat_kind: assert property (@(posedge hclk) disable iff (!hreset)
      beat_on_bus |-> ahb_ctrl.htrans == (exp_first ? NONSEQ : SEQ))
      else fail_value("htrans", 32'($sampled(ahb_ctrl.htrans)),
                      $sampled(exp_first) ? 32'(NONSEQ) : 32'(SEQ));

   a_beat_count: assert property (@(posedge hclk) disable iff (!hreset)
      beat_on_bus |-> exp_left != 5'd0)
      else fail_msg("more beats on the bus than the burst type allows");

   a_beat_ctrl: assert property (@(posedge hclk) disable iff (!hreset)
      beat_on_bus |-> (ahb_ctrl.hsize == WORD && ahb_ctrl.hwrite == exp_cmd.write
                       && ahb_ctrl.hburst == exp_cmd.burst))
      else fail_msg("hsize, hwrite or hburst does not match the command");

   a_wait_stable: assert property (@(posedge hclk) disable iff (!hreset)
      !hready |=> ($stable(ahb_ctrl) && $stable(hwdata)))
      else fail_msg("ahb_ctrl_o or hwdata_o changed during a wait state");

   a_req_after_cmd: assert property (@(posedge hclk) disable iff (!hreset)
      $rose(hbusreq) |-> $past(cmd_valid_i && !busy_o))
      else fail_msg("hbusreq_o rose without an accepted command");

   a_nonseq_granted: assert property (@(posedge hclk) disable iff (!hreset)
      ahb_ctrl.htrans != IDLE |-> hgrant)
      else fail_msg("transfer driven without grant");

   a_req_drop: assert property (@(posedge hclk) disable iff (!hreset)
      (ahb_ctrl.htrans == NONSEQ && hready) |=> !hbusreq)
      else fail_msg("hbusreq_o still high after the first beat was taken");

   a_wdata: assert property (@(posedge hclk) disable iff (!hreset)
      (tdp_valid && tdp_write && hready) |-> hwdata == shadow[tdp_idx])
      else fail_value("hwdata_o", $sampled(hwdata), $sampled(shadow[tdp_idx]));

   a_busy_end: assert property (@(posedge hclk) disable iff (!hreset)
      $fell(busy_o) |-> (exp_left == 5'd0 && !tdp_valid))
      else fail_msg("busy_o fell before the last data phase completed");

   a_busy_start: assert property (@(posedge hclk) disable iff (!hreset)
      $rose(busy_o) |-> $past(cmd_valid_i))
      else fail_msg("busy_o rose without a command");

   // ************************************************************************
   // Stimulus
   // ************************************************************************
   task automatic wait_not_busy();
      int cycles;
      cycles = 0;
      @(negedge hclk);
      while (busy_o) begin
         if (cycles == TIMEOUT) begin
            fail_msg("timed out waiting for busy_o to fall");
         end else begin
            cycles++;
            @(negedge hclk);
         end
      end
   endtask

   function automatic logic all_filled(input int word, input int len);
      logic ok;
      ok = 1'b1;
      for (int i = 0; i < len; i++) begin
         if (!filled[(word + i) % 64]) ok = 1'b0;
      end
      return ok;
   endfunction

   task automatic run_command(input dma_cmd_t c);
      dma_cmd_t junk;
      junk.write = 1'b0;
      junk.burst = INCR16;
      junk.addr  = BASE;
      wait_not_busy();
      @(posedge hclk);
      cmd_i       <= c;
      cmd_valid_i <= 1'b1;
      @(posedge hclk);
      cmd_valid_i <= 1'b0;
      // Extra request while busy that must be ignored
      @(posedge hclk);
      cmd_i       <= junk;
      cmd_valid_i <= 1'b1;
      @(posedge hclk);
      cmd_valid_i <= 1'b0;
      wait_not_busy();
   endtask

   initial begin
      dma_cmd_t c;
      int       len;
      int       word;
      void'($urandom(SEED));
      hreset      = 1'b0;
      cmd_valid_i = 1'b0;
      cmd_i       = '0;
      for (int i = 0; i < 64; i++) begin
         filled[i] = 1'b0;
      end
      repeat (8) @(posedge hclk);
      hreset <= 1'b1;
      repeat (4) @(posedge hclk);

      for (int n = 0; n < NUM_CMDS; n++) begin
         case ($urandom_range(0, 3))
            0:       c.burst = SINGLE;
            1:       c.burst = INCR4;
            2:       c.burst = INCR8;
            default: c.burst = INCR16;
         endcase
         len     = int'(beats_of(c.burst));
         word    = $urandom_range(0, 256 - len);
         c.addr  = BASE + 32'(word * 4);
         c.write = ($urandom_range(0, 1) == 1) && all_filled(word, len);
         if (!c.write) begin
            for (int i = 0; i < len; i++) filled[(word + i) % 64] = 1'b1;
         end
         run_command(c);
      end

      repeat (10) @(posedge hclk);
      $display("Test OK");
      $finish;
   end

endmodule

`default_nettype wire

// File: hw/ahbm_data_phase.sv
`timescale 1ns/1ps
`default_nettype none

module ahbm_data_phase (
   input  wire                             hclk,
   input  wire                             hreset,
   input  wire ahbm_pkg::beat_t            aphase_i,
   input  wire                             hready_i,
   input  wire ahbm_pkg::hresp_t           hresp_i,
   input  wire [ahbm_pkg::HDATA_W-1:0]     hrdata_i,
   output logic [ahbm_pkg::HDATA_W-1:0]    hwdata_o,
   // Buffer ports
   output logic                            buf_wr_en_o,
   output logic [ahbm_pkg::BUF_IDX_W-1:0]  buf_wr_idx_o,
   output logic [ahbm_pkg::HDATA_W-1:0]    buf_wr_data_o,
   output logic [ahbm_pkg::BUF_IDX_W-1:0]  buf_rd_idx_o,
   input  wire [ahbm_pkg::HDATA_W-1:0]     buf_rd_data_i,
   output logic                            burst_done_o
);
   import ahbm_pkg::*;

   beat_t   dp_q;       // Beat now in its data phase
   logic    dp_done;    // Its data phase ends on this edge

   assign dp_done = dp_q.valid && hready_i;

   // *************************************************************************
   // Data-phase tracking
   // *************************************************************************
   always_ff @(posedge hclk) begin
      if (!hreset) begin
         dp_q         <= '0;
         burst_done_o <= 1'b0;
         hwdata_o     <= '0;
      end else begin
         if (hready_i) begin
            dp_q <= aphase_i;    // Empty beat when no address was taken
         end
         burst_done_o <= dp_done && dp_q.last;
         // Write word fetched as its address phase is taken
         if (aphase_i.valid && aphase_i.write) begin
            hwdata_o <= buf_rd_data_i;
         end
      end
   end

   assign buf_rd_idx_o = aphase_i.idx;

   // Read data lands in the buffer at the completing edge
   assign buf_wr_en_o   = dp_done && !dp_q.write;
   assign buf_wr_idx_o  = dp_q.idx;
   assign buf_wr_data_o = hrdata_i;

   // *************************************************************************
   // Checks
   // *************************************************************************

   // Only OKAY is handled
   a_resp_okay: assert property (@(posedge hclk) disable iff (!hreset)
      dp_q.valid |-> (hresp_i == OKAY))
      else $error("Slave response other than OKAY");

endmodule

`default_nettype wire

// File: hw/ahbm_pkg.sv
`default_nettype none

package ahbm_pkg;

   // *************************************************************************
   // Bus and buffer widths
   // *************************************************************************
   localparam int HADDR_W    = 32;
   localparam int HDATA_W    = 32;
   localparam int BUF_IDX_W  = 6;    // Word index from haddr[7:2]
   localparam int BUF_DEPTH  = 64;
   localparam int BEAT_CNT_W = 5;    // Holds up to 16 beats

   // *************************************************************************
   // AHB encodings
   // *************************************************************************
   typedef enum logic [1:0] {
      IDLE   = 2'b00,
      BUSY   = 2'b01,
      NONSEQ = 2'b10,
      SEQ    = 2'b11
   } htrans_t;

   typedef enum logic [2:0] {
      SINGLE = 3'b000,
      INCR   = 3'b001,
      INCR4  = 3'b011,
      INCR8  = 3'b101,
      INCR16 = 3'b111
   } hburst_t;

   typedef enum logic [2:0] {
      BYTE     = 3'b000,
      HALFWORD = 3'b001,
      WORD     = 3'b010
   } hsize_t;

   typedef enum logic [1:0] {
      OKAY  = 2'b00,
      ERROR = 2'b01,
      RETRY = 2'b10,
      SPLIT = 2'b11
   } hresp_t;

   // *************************************************************************
   // Bundles
   // *************************************************************************

   // Master address-phase outputs
   typedef struct packed {
      htrans_t              htrans;
      logic                 hwrite;
      hsize_t               hsize;
      hburst_t              hburst;
      logic [HADDR_W-1:0]   haddr;
   } ahb_ctrl_t;

   typedef struct packed {
      logic                 write;   // 1 moves buffer words onto the bus
      hburst_t              burst;
      logic [HADDR_W-1:0]   addr;    // Word aligned
   } dma_cmd_t;

   // Address phase just taken by the bus
   typedef struct packed {
      logic                 valid;
      logic                 write;
      logic                 last;
      logic [BUF_IDX_W-1:0] idx;
   } beat_t;

endpackage

`default_nettype wire

// File: hw/ahbm_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module ahbm_sequencer (
   input  wire                        hclk,
   input  wire                        hreset,
   input  wire ahbm_pkg::dma_cmd_t    cmd_i,
   input  wire                        cmd_valid_i,
   output logic                       busy_o,
   input  wire                        hgrant_i,
   output logic                       hbusreq_o,
   input  wire                        hready_i,
   output ahbm_pkg::ahb_ctrl_t        ahb_ctrl_o,
   output ahbm_pkg::beat_t            aphase_o,
   input  wire                        burst_done_i
);
   import ahbm_pkg::*;

   // *************************************************************************
   // State encoding
   // *************************************************************************
   typedef enum logic [1:0] {
      S_IDLE  = 2'b00,   // Waiting for a command
      S_BREQ  = 2'b01,   // Bus requested and waiting for grant
      S_ADDR  = 2'b10,   // Driving address phases
      S_DRAIN = 2'b11    // Last address taken with data still in flight
   } seq_state_t;

   seq_state_t              state;
   dma_cmd_t                cmd_q;
   logic [BEAT_CNT_W-1:0]   beats_left;    // Address phases still to go
   htrans_t                 htrans_q;
   logic                    hwrite_q;
   hburst_t                 hburst_q;
   logic [HADDR_W-1:0]      haddr_q;

   logic                    cmd_accept;
   logic                    grant_taken;
   logic                    beat_accept;
   logic                    last_beat;

   // Beats in a fixed-length burst
   function automatic logic [BEAT_CNT_W-1:0] burst_len(input hburst_t burst);
      case (burst)
         INCR4:   burst_len = BEAT_CNT_W'(4);
         INCR8:   burst_len = BEAT_CNT_W'(8);
         INCR16:  burst_len = BEAT_CNT_W'(16);
         default: burst_len = BEAT_CNT_W'(1);
      endcase
   endfunction

   assign busy_o      = (state != S_IDLE);
   assign cmd_accept  = cmd_valid_i && !busy_o;
   assign grant_taken = (state == S_BREQ) && hgrant_i && hready_i;
   assign beat_accept = (state == S_ADDR) && hready_i;
   assign last_beat   = (beats_left == BEAT_CNT_W'(1));

   // *************************************************************************
   // Bus outputs
   // *************************************************************************
   always_comb begin
      ahb_ctrl_o.htrans = htrans_q;
      ahb_ctrl_o.hwrite = hwrite_q;
      ahb_ctrl_o.hsize  = WORD;         // Word transfers only
      ahb_ctrl_o.hburst = hburst_q;
      ahb_ctrl_o.haddr  = haddr_q;
   end

   // Beat handed over to the data side on its acceptance edge
   always_comb begin
      aphase_o.valid = beat_accept;
      aphase_o.write = hwrite_q;
      aphase_o.last  = last_beat;
      aphase_o.idx   = haddr_q[BUF_IDX_W+1:2];
   end

   // Command copy taken once and read at grant
   always_ff @(posedge hclk) begin
      if (cmd_accept) begin
         cmd_q <= cmd_i;
      end
   end

   // *************************************************************************
   // Address-phase state machine
   // *************************************************************************
   always_ff @(posedge hclk) begin
      if (!hreset) begin
         state      <= S_IDLE;
         hbusreq_o  <= 1'b0;
         beats_left <= '0;
         htrans_q   <= IDLE;
         hwrite_q   <= 1'b0;
         hburst_q   <= SINGLE;
         haddr_q    <= '0;
      end else begin
         case (state)
            S_IDLE: begin
               if (cmd_accept) begin
                  hbusreq_o  <= 1'b1;
                  beats_left <= burst_len(cmd_i.burst);
                  state      <= S_BREQ;
               end
            end

            S_BREQ: begin
               if (grant_taken) begin    // First NONSEQ next cycle
                  htrans_q <= NONSEQ;
                  hwrite_q <= cmd_q.write;
                  hburst_q <= cmd_q.burst;
                  haddr_q  <= cmd_q.addr;
                  state    <= S_ADDR;
               end
            end

            S_ADDR: begin
               if (beat_accept) begin
                  hbusreq_o <= 1'b0;     // Fixed length so the bus need not be held
                  if (last_beat) begin
                     htrans_q <= IDLE;
                     state    <= S_DRAIN;
                  end else begin
                     htrans_q   <= SEQ;
                     haddr_q    <= haddr_q + HADDR_W'(4);
                     beats_left <= beats_left - BEAT_CNT_W'(1);
                  end
               end
            end

            S_DRAIN: begin
               // Last data phase done
               if (burst_done_i) begin
                  state <= S_IDLE;
               end
            end

            default: state <= S_IDLE;
         endcase
      end
   end

   // *************************************************************************
   // Checks
   // *************************************************************************

   // Wait states freeze the address phase
   a_ctrl_stable: assert property (@(posedge hclk) disable iff (!hreset)
      !hready_i |=> $stable(ahb_ctrl_o))
      else $error("ahb_ctrl_o changed under a wait state");

   a_cmd_aligned: assert property (@(posedge hclk) disable iff (!hreset)
      cmd_accept |-> (cmd_i.addr[1:0] == 2'b00))
      else $error("Command address not word aligned");

   // A SEQ beat sitting on a 1 KB line means the burst wrapped into the next one
   a_no_1k_cross: assert property (@(posedge hclk) disable iff (!hreset)
      (htrans_q == SEQ) |-> (haddr_q[9:0] != 10'd0))
      else $error("Burst crosses a 1 KB boundary");

endmodule

`default_nettype wire

// File: hw/ahbm_top.sv
`timescale 1ns/1ps
`default_nettype none

module ahbm_top (
   input  wire                           hclk,
   input  wire                           hreset,
   // Command side
   input  wire ahbm_pkg::dma_cmd_t       cmd_i,
   input  wire                           cmd_valid_i,
   output logic                          busy_o,
   // Arbiter
   input  wire                           hgrant_i,
   output logic                          hbusreq_o,
   // AHB master
   output ahbm_pkg::ahb_ctrl_t           ahb_ctrl_o,
   input  wire                           hready_i,
   input  wire ahbm_pkg::hresp_t         hresp_i,
   output logic [ahbm_pkg::HDATA_W-1:0]  hwdata_o,
   input  wire [ahbm_pkg::HDATA_W-1:0]   hrdata_i
);
   import ahbm_pkg::*;

   beat_t                  aphase;       // Beat accepted this cycle
   logic                   burst_done;
   logic                   buf_wr_en;
   logic [BUF_IDX_W-1:0]   buf_wr_idx;
   logic [HDATA_W-1:0]     buf_wr_data;
   logic [BUF_IDX_W-1:0]   buf_rd_idx;
   logic [HDATA_W-1:0]     buf_rd_data;

   // Address side
   ahbm_sequencer sequencer_inst (
      .hclk         (hclk),
      .hreset       (hreset),
      .cmd_i        (cmd_i),
      .cmd_valid_i  (cmd_valid_i),
      .busy_o       (busy_o),
      .hgrant_i     (hgrant_i),
      .hbusreq_o    (hbusreq_o),
      .hready_i     (hready_i),
      .ahb_ctrl_o   (ahb_ctrl_o),
      .aphase_o     (aphase),
      .burst_done_i (burst_done)
   );

   // Data side
   ahbm_data_phase data_phase_inst (
      .hclk          (hclk),
      .hreset        (hreset),
      .aphase_i      (aphase),
      .hready_i      (hready_i),
      .hresp_i       (hresp_i),
      .hrdata_i      (hrdata_i),
      .hwdata_o      (hwdata_o),
      .buf_wr_en_o   (buf_wr_en),
      .buf_wr_idx_o  (buf_wr_idx),
      .buf_wr_data_o (buf_wr_data),
      .buf_rd_idx_o  (buf_rd_idx),
      .buf_rd_data_i (buf_rd_data),
      .burst_done_o  (burst_done)
   );

   ahbm_word_buffer word_buffer_inst (
      .hclk      (hclk),
      .wr_en_i   (buf_wr_en),
      .wr_idx_i  (buf_wr_idx),
      .wr_data_i (buf_wr_data),
      .rd_idx_i  (buf_rd_idx),
      .rd_data_o (buf_rd_data)
   );

endmodule

`default_nettype wire

// File: hw/ahbm_word_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module ahbm_word_buffer (
   input  wire                             hclk,
   input  wire                             wr_en_i,
   input  wire [ahbm_pkg::BUF_IDX_W-1:0]   wr_idx_i,
   input  wire [ahbm_pkg::HDATA_W-1:0]     wr_data_i,
   input  wire [ahbm_pkg::BUF_IDX_W-1:0]   rd_idx_i,
   output logic [ahbm_pkg::HDATA_W-1:0]    rd_data_o
);
   import ahbm_pkg::*;

   // One word per index
   logic [HDATA_W-1:0] mem [BUF_DEPTH];

   always_ff @(posedge hclk) begin
      if (wr_en_i) begin
         mem[wr_idx_i] <= wr_data_i;
      end
   end

   assign rd_data_o = mem[rd_idx_i];    // Combinational read

   // Index comes from the tracked data-phase beat
   a_wr_idx_known: assert property (@(posedge hclk)
      wr_en_i |-> !$isunknown(wr_idx_i))
      else $error("Buffer write with unknown index");

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the AHB burst engine testbench with Verilator and run it.
# A failing check ends the run through $fatal, which gives a nonzero exit status.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert \
   --top-module ahbm_tb \
   -f ahbm_top.f \
   --Mdir obj_dir \
   -o ahbm_sim

./obj_dir/ahbm_sim
